/* bench/rvc_cases.txt */
# name inst b2b rd wr wdata next_pc status, values in hex for inst wdata next_pc
# b2b 1 strobes right after the previous case, status 0 ok 1 illegal 2 trap
addi_x3_rst 019D 0 3 1 00000007 00000002 0
li_x1_pos 4095 0 1 1 00000005 00000004 0
addi_x1_neg 10F5 1 1 1 00000002 00000006 0
li_sp 4141 0 2 1 00000010 00000008 0
lui_pos 6205 0 4 1 00001000 0000000A 0
lui_neg 72FD 1 5 1 FFFFF000 0000000C 0
addi16sp_neg 713D 0 2 1 FFFFFFF0 0000000E 0
addi16sp_pos 6145 1 2 1 00000020 00000010 0
addi4spn_8 0020 1 8 1 00000028 00000012 0
addi4spn_260 0244 0 9 1 00000124 00000014 0
mv_x10 850E 0 10 1 00000007 00000016 0
add_x10 9522 1 10 1 0000002F 00000018 0
sub_x10 8D01 1 10 1 00000007 0000001A 0
xor_x10 8D25 1 10 1 00000123 0000001C 0
or_x10 8D41 1 10 1 0000012B 0000001E 0
and_x10 8D65 1 10 1 00000120 00000020 0
slli_x10 0506 1 10 1 00000240 00000022 0
srli_x10 810D 1 10 1 00000048 00000024 0
andi_x10 8931 1 10 1 00000008 00000026 0
mv_x11 8596 0 11 1 FFFFF000 00000028 0
srai_x11 8591 1 11 1 FFFFFF00 0000002A 0
j_fwd A019 0 0 0 00000000 00000030 0
jal_back 3FE5 1 1 1 00000032 00000028 0
jr_x1 8082 1 0 0 00000000 00000032 0
jalr_x4 9202 0 1 1 00000034 00001000 0
beqz_taken C609 1 0 0 00000000 0000100A 0
beqz_not C509 0 0 0 00000000 0000100C 0
bnez_taken FD75 1 0 0 00000000 00001008 0
bnez_not E201 0 0 0 00000000 0000100A 0
c_lw 4000 0 0 0 00000000 0000100C 1
c_sw C000 1 0 0 00000000 0000100E 1
c_lwsp 4002 0 0 0 00000000 00001010 1
c_swsp C002 1 0 0 00000000 00001012 1
full_32bit 0013 0 0 0 00000000 00001014 1
spn_zero 0000 1 0 0 00000000 00001016 1
li_x16 4805 0 0 0 00000000 00001018 1
ebreak 9002 1 0 0 00000000 0000101A 2

/* all.f */
src/rvc_isa_pkg.sv
src/core_pkg.sv
src/rvc_decoder.sv
src/rvc_execute.sv
src/rvc_writeback.sv
src/rvc_core_top.sv
bench/rvc_core_properties.sv
bench/tb_rvc_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_rvc_core -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

/* bench/tb_rvc_core.sv */
`timescale 1ns/1ps

module tb_rvc_core
    import core_pkg::*;
;

    localparam int MAX_CASES = 64;
    localparam int DRAIN_LIMIT = 50;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [15:0] inst;
    retire_t     retire;

    logic [8*16-1:0] c_name    [MAX_CASES];
    logic [15:0]     c_inst    [MAX_CASES];
    logic            c_b2b     [MAX_CASES];
    logic [3:0]      c_rd      [MAX_CASES];
    logic            c_wr      [MAX_CASES];
    logic [31:0]     c_wdata   [MAX_CASES];
    logic [31:0]     c_next_pc [MAX_CASES];
    logic [1:0]      c_status  [MAX_CASES];
    int              num_cases;

    int          exp_q[$];          // case index per instruction in flight
    logic [31:0] exp_pc;            // pc of the next instruction to retire
    int          errors;
    int          checked;

    rvc_core_top DUT (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_inst_valid (inst_valid),
        .i_inst       (inst),
        .o_retire     (retire)
    );

    always #20 clk = ~clk;

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [8*16-1:0] name;
        logic [15:0] f_inst;
        int          f_b2b;
        int          f_rd;
        int          f_wr;
        logic [31:0] f_wdata;
        logic [31:0] f_next;
        int          f_status;
        num_cases = 0;
        fd = $fopen("bench/rvc_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file");
            errors++;
            return;
        end
        while (!$feof(fd) && num_cases < MAX_CASES) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0 || line[0] == 8'h23) begin
                continue;   // blank or comment
            end
            n = $sscanf(line, "%s %h %d %d %d %h %h %d", name, f_inst, f_b2b, f_rd,
                        f_wr, f_wdata, f_next, f_status);
            if (n != 8) begin
                continue;
            end
            c_name[num_cases]    = name;
            c_inst[num_cases]    = f_inst;
            c_b2b[num_cases]     = (f_b2b != 0);
            c_rd[num_cases]      = f_rd[3:0];
            c_wr[num_cases]      = (f_wr != 0);
            c_wdata[num_cases]   = f_wdata;
            c_next_pc[num_cases] = f_next;
            c_status[num_cases]  = f_status[1:0];
            num_cases++;
        end
        $fclose(fd);
    endtask

    // compares one retire record against the case at the head of the queue
    task automatic check_retire();
        int idx;
        if (exp_q.size() == 0) begin
            $display("retire arrived with no instruction outstanding");
            errors++;
            return;
        end
        idx = exp_q.pop_front();
        checked++;
        assert (retire.pc == exp_pc) else begin
            $display("[FAIL] %0s pc: expected %h, actual %h", c_name[idx], exp_pc, retire.pc);
            errors++;
        end
        assert (retire.wr == c_wr[idx]) else begin
            $display("[FAIL] %0s wr: expected %0d, actual %0d", c_name[idx], c_wr[idx],
                     retire.wr);
            errors++;
        end
        if (c_wr[idx]) begin  // rd and data only mean something on a write
            assert (retire.rd == c_rd[idx]) else begin
                $display("[FAIL] %0s rd: expected %0d, actual %0d", c_name[idx], c_rd[idx],
                         retire.rd);
                errors++;
            end
            assert (retire.wdata == c_wdata[idx]) else begin
                $display("[FAIL] %0s wdata: expected %h, actual %h", c_name[idx],
                         c_wdata[idx], retire.wdata);
                errors++;
            end
        end
        assert (retire.next_pc == c_next_pc[idx]) else begin
            $display("[FAIL] %0s next_pc: expected %h, actual %h", c_name[idx],
                     c_next_pc[idx], retire.next_pc);
            errors++;
        end
        assert (retire.status == c_status[idx]) else begin
            $display("[FAIL] %0s status: expected %0d, actual %0d", c_name[idx],
                     c_status[idx], retire.status);
            errors++;
        end
        exp_pc = c_next_pc[idx];
    endtask

    // sample away from the driving edge
    always @(negedge clk) begin
        if (rst_n && retire.valid) begin
            check_retire();
        end
    end

    initial begin
        int          gap;
        int          waited;
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        errors     = 0;
        checked    = 0;
        exp_pc     = '0;
        void'($urandom(32'h571d_de60));
        load_cases();

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < num_cases; i++) begin
            gap = c_b2b[i] ? 0 : int'($urandom % 3);
            repeat (gap) begin
                @(posedge clk);
                inst_valid <= 1'b0;
            end
            @(posedge clk);
            inst_valid <= 1'b1;
            inst       <= c_inst[i];
            exp_q.push_back(i);
        end
        @(posedge clk);
        inst_valid <= 1'b0;

        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("retire never arrived for %0d instructions", exp_q.size());
            errors++;
        end
        if (checked != num_cases || num_cases == 0) begin
            $display("retired %0d instructions out of %0d cases", checked, num_cases);
            errors++;
        end

        $display("errors: %0d, retires checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* bench/rvc_core_properties.sv */
`timescale 1ns/1ps

module rvc_core_properties
    import core_pkg::*;
(
    input logic    i_clk,
    input logic    i_rst_n,
    input logic    i_inst_valid,
    input retire_t o_retire
);

    // quiet during reset and the cycle after it
    property p_quiet_after_reset;
        @(posedge i_clk) !i_rst_n |=> !o_retire.valid ##1 !o_retire.valid;
    endproperty

    property p_retire_latency;
        @(posedge i_clk) disable iff (!i_rst_n)
            i_inst_valid |-> ##3 o_retire.valid;
    endproperty

    property p_write_legal;
        @(posedge i_clk) disable iff (!i_rst_n)
            (o_retire.valid && o_retire.wr) |-> (o_retire.rd != '0) && (o_retire.status == ok);
    endproperty

    a_quiet_after_reset: assert property (p_quiet_after_reset)
        else $error("retire seen during or right after reset");
    a_retire_latency: assert property (p_retire_latency)
        else $error("no retire three cycles after a strobe");
    a_write_legal: assert property (p_write_legal)
        else $error("write to x0 or write with a non-ok status");

endmodule

bind rvc_core_top rvc_core_properties u_props (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .o_retire     (o_retire)
);

/* src/rvc_core_top.sv */
`timescale 1ns/1ps

module rvc_core_top
    import core_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_inst_valid,
    input  logic [15:0] i_inst,
    output retire_t     o_retire
);

    decoded_t          dec;
    executed_t         exe;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [PC_W-1:0]   pc_fetch;   // pc for the next decoded instruction

    rvc_decoder u_decoder (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .i_pc         (pc_fetch),
        .o_dec        (dec)
    );

    rvc_execute u_execute (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_dec           (dec),
        .o_rs1_addr      (rs1_addr),
        .o_rs2_addr      (rs2_addr),
        .i_rs1_data      (rs1_data),
        .i_rs2_data      (rs2_data),
        .o_pc_next_fetch (pc_fetch),
        .o_exe           (exe)
    );

    rvc_writeback u_writeback (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_exe      (exe),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .o_retire   (o_retire)
    );

endmodule

/* src/rvc_writeback.sv */
`timescale 1ns/1ps

module rvc_writeback
    import core_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  executed_t         i_exe,
    input  logic [REG_AW-1:0] i_rs1_addr,
    input  logic [REG_AW-1:0] i_rs2_addr,
    output logic [XLEN-1:0]   o_rs1_data,
    output logic [XLEN-1:0]   o_rs2_data,
    output retire_t           o_retire
);

    logic [XLEN-1:0] regs [REG_COUNT];
    logic            we;

    assign we = i_exe.valid && i_exe.wr && (i_exe.rd != '0);  // x0 never written

    // write-first read, the entry written this cycle wins
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (we && (addr == i_exe.rd)) begin
            return i_exe.wdata;
        end
        return regs[addr];
    endfunction

    always_comb o_rs1_data = read_reg(i_rs1_addr);
    always_comb o_rs2_data = read_reg(i_rs2_addr);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            o_retire.valid <= 1'b0;
        end else begin
            if (we) begin
                regs[i_exe.rd] <= i_exe.wdata;
            end
            if (i_exe.valid) begin
                o_retire.rd      <= i_exe.rd;
                o_retire.wr      <= we;          // reports only real writes
                o_retire.wdata   <= i_exe.wdata;
                o_retire.pc      <= i_exe.pc;
                o_retire.next_pc <= i_exe.next_pc;
                o_retire.status  <= i_exe.status;
            end
            o_retire.valid <= i_exe.valid;
        end
    end

endmodule

/* src/rvc_execute.sv */
`timescale 1ns/1ps

module rvc_execute
    import rvc_isa_pkg::*;
    import core_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  decoded_t          i_dec,
    output logic [REG_AW-1:0] o_rs1_addr,
    output logic [REG_AW-1:0] o_rs2_addr,
    input  logic [XLEN-1:0]   i_rs1_data,
    input  logic [XLEN-1:0]   i_rs2_data,
    output logic [PC_W-1:0]   o_pc_next_fetch,
    output executed_t         o_exe
);

    executed_t       exe_q;
    executed_t       exe_d;
    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] pc_seq;
    logic [PC_W-1:0] pc_tgt;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;

    assign o_rs1_addr = i_dec.rs1;
    assign o_rs2_addr = i_dec.rs2;

    // write-first read ports already return the result one ahead
    assign op_a = i_dec.a_from_reg ? i_rs1_data : '0;
    assign op_b = i_dec.b_from_imm ? i_dec.imm : i_rs2_data;

    always_comb begin
        case (i_dec.alu_op)
            add:     alu_out = op_a + op_b;
            sub:     alu_out = op_a - op_b;
            and_op:  alu_out = op_a & op_b;
            or_op:   alu_out = op_a | op_b;
            xor_op:  alu_out = op_a ^ op_b;
            sll:     alu_out = op_a << op_b[4:0];
            srl:     alu_out = op_a >> op_b[4:0];
            sra:     alu_out = $signed(op_a) >>> op_b[4:0];
            pass_b:  alu_out = op_b;
            default: alu_out = '0;
        endcase
    end

    assign pc_seq = i_dec.pc + PC_W'(2);
    assign pc_tgt = i_dec.pc + i_dec.imm;

    always_comb begin
        exe_d.valid   = i_dec.valid;
        exe_d.rd      = i_dec.rd;
        exe_d.wr      = 1'b0;
        exe_d.wdata   = alu_out;
        exe_d.pc      = i_dec.pc;
        exe_d.next_pc = pc_seq;
        exe_d.status  = ok;
        case (i_dec.kind)
            kind_alu_reg, kind_alu_imm: exe_d.wr = 1'b1;
            kind_jump: begin
                exe_d.wr      = 1'b1;    // rd is x0 for j
                exe_d.wdata   = pc_seq;
                exe_d.next_pc = pc_tgt;
            end
            kind_jump_reg: begin
                exe_d.wr      = 1'b1;
                exe_d.wdata   = pc_seq;
                exe_d.next_pc = {i_rs1_data[PC_W-1:1], 1'b0};
            end
            kind_branch_eqz: if (i_rs1_data == '0) exe_d.next_pc = pc_tgt;
            kind_branch_nez: if (i_rs1_data != '0) exe_d.next_pc = pc_tgt;
            kind_trap:       exe_d.status = trap;
            default:         exe_d.status = illegal;
        endcase
    end

    // decode samples the pc this instruction hands on
    assign o_pc_next_fetch = i_dec.valid ? exe_d.next_pc : pc_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_q        <= '0;
            exe_q.valid <= 1'b0;
        end else begin
            if (i_dec.valid) begin
                pc_q  <= exe_d.next_pc;
                exe_q <= exe_d;
            end
            exe_q.valid <= i_dec.valid;
        end
    end

    assign o_exe = exe_q;

endmodule

/* src/rvc_decoder.sv */
`timescale 1ns/1ps

module rvc_decoder
    import rvc_isa_pkg::*;
    import core_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_inst_valid,
    input  logic [15:0]     i_inst,
    input  logic [PC_W-1:0] i_pc,
    output decoded_t        o_dec
);

    quadrant_e  quad;
    logic [2:0] funct3;
    logic       funct4;
    logic [1:0] funct2;
    logic [1:0] funct2_lo;
    logic [4:0] rd_full;     // CR/CI register field
    logic [4:0] rs2_full;
    logic [4:0] rs1_c;       // 3-bit fields map to x8..x15
    logic [4:0] rs2_c;

    insn_kind_e kind;
    alu_op_e    alu_op;
    imm_fmt_e   fmt;
    logic [4:0] rd_w;
    logic [4:0] rs1_w;
    logic [4:0] rs2_w;
    logic       a_reg;
    logic       b_imm;
    logic       rsvd;        // reserved encoding seen
    logic [XLEN-1:0] imm;
    decoded_t   dec_d;

    assign quad      = quadrant_e'(i_inst[1:0]);
    assign funct3    = i_inst[15:13];
    assign funct4    = i_inst[12];
    assign funct2    = i_inst[11:10];
    assign funct2_lo = i_inst[6:5];
    assign rd_full   = i_inst[11:7];
    assign rs2_full  = i_inst[6:2];
    assign rs1_c     = {2'b01, i_inst[9:7]};
    assign rs2_c     = {2'b01, i_inst[4:2]};

    always_comb begin
        kind   = kind_illegal;
        alu_op = add;
        fmt    = none;
        rd_w   = '0;
        rs1_w  = '0;
        rs2_w  = '0;
        a_reg  = 1'b0;
        b_imm  = 1'b0;
        rsvd   = 1'b0;

        case (quad)
            q0: begin
                case (funct3)
                    f3_addi4spn: begin  // addi rd', x2, nzuimm
                        kind  = kind_alu_imm;
                        rd_w  = rs2_c;
                        rs1_w = 5'd2;
                        a_reg = 1'b1;
                        b_imm = 1'b1;
                        fmt   = ciw_spn;
                        rsvd  = (i_inst[12:5] == 8'd0);
                    end
                    f3_lw, f3_sw: kind = kind_illegal;  // no data memory
                    default: kind = kind_illegal;
                endcase
            end
            q1: begin
                case (funct3)
                    f3_addi, f3_li: begin
                        kind  = kind_alu_imm;
                        rd_w  = rd_full;
                        rs1_w = rd_full;
                        a_reg = (funct3 == f3_addi);  // li adds to zero
                        b_imm = 1'b1;
                        fmt   = ci;
                    end
                    f3_jal, f3_j: begin
                        kind = kind_jump;
                        rd_w = (funct3 == f3_jal) ? 5'd1 : 5'd0;
                        fmt  = cj;
                    end
                    f3_lui: begin
                        kind  = kind_alu_imm;
                        rd_w  = rd_full;
                        b_imm = 1'b1;
                        rsvd  = ({i_inst[12], i_inst[6:2]} == 6'd0);
                        if (rd_full == 5'd2) begin  // addi16sp
                            rs1_w = 5'd2;
                            a_reg = 1'b1;
                            fmt   = ci_sp16;
                        end else begin
                            alu_op = pass_b;
                            fmt    = ci_lui;
                        end
                    end
                    f3_arith: begin
                        rd_w  = rs1_c;
                        rs1_w = rs1_c;
                        a_reg = 1'b1;
                        case (funct2)
                            2'd0, 2'd1: begin
                                kind   = kind_alu_imm;
                                alu_op = (funct2 == 2'd0) ? srl : sra;
                                b_imm  = 1'b1;
                                fmt    = ci;
                                rsvd   = funct4;  // shamt[5] not on rv32
                            end
                            2'd2: begin
                                kind   = kind_alu_imm;
                                alu_op = and_op;
                                b_imm  = 1'b1;
                                fmt    = ci;
                            end
                            default: begin
                                kind  = kind_alu_reg;
                                rs2_w = rs2_c;
                                rsvd  = funct4;   // subw/addw group
                                case (funct2_lo)
                                    2'd0:    alu_op = sub;
                                    2'd1:    alu_op = xor_op;
                                    2'd2:    alu_op = or_op;
                                    default: alu_op = and_op;
                                endcase
                            end
                        endcase
                    end
                    f3_beqz, f3_bnez: begin
                        kind  = (funct3 == f3_beqz) ? kind_branch_eqz : kind_branch_nez;
                        rs1_w = rs1_c;
                        fmt   = cb;
                    end
                    default: kind = kind_illegal;
                endcase
            end
            q2: begin
                case (funct3)
                    f3_slli: begin
                        kind   = kind_alu_imm;
                        alu_op = sll;
                        rd_w   = rd_full;
                        rs1_w  = rd_full;
                        a_reg  = 1'b1;
                        b_imm  = 1'b1;
                        fmt    = ci;
                        rsvd   = funct4;
                    end
                    f3_cr: begin
                        rs1_w = rd_full;
                        if (rs2_full != 5'd0) begin  // mv or add
                            kind  = kind_alu_reg;
                            rd_w  = rd_full;
                            rs2_w = rs2_full;
                            a_reg = funct4;            // mv takes zero + rs2
                        end else if (!funct4) begin
                            kind = kind_jump_reg;      // jr
                            rsvd = (rd_full == 5'd0);
                        end else if (rd_full == 5'd0) begin
                            kind = kind_trap;          // ebreak
                        end else begin
                            kind = kind_jump_reg;      // jalr links x1
                            rd_w = 5'd1;
                        end
                    end
                    f3_lwsp, f3_swsp: kind = kind_illegal;
                    default: kind = kind_illegal;
                endcase
            end
            default: kind = kind_illegal;  // 32-bit encodings
        endcase
    end

    // immediate assembly per the rvc immediate table
    always_comb begin
        case (fmt)
            ci:      imm = {{26{i_inst[12]}}, i_inst[12], i_inst[6:2]};
            ci_lui:  imm = {{14{i_inst[12]}}, i_inst[12], i_inst[6:2], 12'd0};
            ci_sp16: imm = {{22{i_inst[12]}}, i_inst[12], i_inst[4:3], i_inst[5], i_inst[2],
                            i_inst[6], 4'd0};
            ciw_spn: imm = {22'd0, i_inst[10:7], i_inst[12:11], i_inst[5], i_inst[6], 2'd0};
            cj:      imm = {{20{i_inst[12]}}, i_inst[12], i_inst[8], i_inst[10:9], i_inst[6],
                            i_inst[7], i_inst[2], i_inst[11], i_inst[5:3], 1'b0};
            cb:      imm = {{23{i_inst[12]}}, i_inst[12], i_inst[6:5], i_inst[2], i_inst[11:10],
                            i_inst[4:3], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        dec_d.valid      = i_inst_valid;
        dec_d.kind       = (rsvd || rd_w[4] || rs1_w[4] || rs2_w[4]) ? kind_illegal : kind;
        dec_d.alu_op     = alu_op;
        dec_d.rs1        = rs1_w[REG_AW-1:0];
        dec_d.rs2        = rs2_w[REG_AW-1:0];
        dec_d.rd         = rd_w[REG_AW-1:0];
        dec_d.a_from_reg = a_reg;
        dec_d.b_from_imm = b_imm;
        dec_d.imm        = imm;
        dec_d.pc         = i_pc;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_dec.valid <= 1'b0;
        end else begin
            if (i_inst_valid) begin
                o_dec <= dec_d;
            end
            o_dec.valid <= dec_d.valid;  // one cycle strobe
        end
    end

endmodule

/* src/core_pkg.sv */
package core_pkg;

    import rvc_isa_pkg::*;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 16;  // rv32e sized register file
    localparam int REG_AW    = 4;
    localparam int PC_W      = 32;

    typedef enum logic [2:0] {
        kind_alu_reg,
        kind_alu_imm,
        kind_jump,
        kind_jump_reg,
        kind_branch_eqz,
        kind_branch_nez,
        kind_trap,
        kind_illegal
    } insn_kind_e;

    typedef enum logic [1:0] {
        ok,
        illegal,
        trap
    } retire_status_e;

    typedef struct packed {
        logic              valid;
        insn_kind_e        kind;
        alu_op_e           alu_op;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic              a_from_reg;  // else operand a is zero
        logic              b_from_imm;
        logic [XLEN-1:0]   imm;
        logic [PC_W-1:0]   pc;
    } decoded_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic              wr;
        logic [XLEN-1:0]   wdata;
        logic [PC_W-1:0]   pc;
        logic [PC_W-1:0]   next_pc;
        retire_status_e    status;
    } executed_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic              wr;
        logic [XLEN-1:0]   wdata;
        logic [PC_W-1:0]   pc;
        logic [PC_W-1:0]   next_pc;
        retire_status_e    status;
    } retire_t;

endpackage

/* src/rvc_isa_pkg.sv */
package rvc_isa_pkg;

    // low two opcode bits, q_full marks a 32-bit encoding
    typedef enum logic [1:0] {
        q0     = 2'd0,
        q1     = 2'd1,
        q2     = 2'd2,
        q_full = 2'd3
    } quadrant_e;

    // funct3 groups per quadrant
    typedef enum logic [2:0] {
        f3_addi4spn = 3'd0,
        f3_lw       = 3'd2,
        f3_sw       = 3'd6
    } q0_funct3_e;

    typedef enum logic [2:0] {
        f3_addi  = 3'd0,   // also nop
        f3_jal   = 3'd1,
        f3_li    = 3'd2,
        f3_lui   = 3'd3,   // lui or addi16sp, split on rd
        f3_arith = 3'd4,   // srli, srai, andi and the CA group
        f3_j     = 3'd5,
        f3_beqz  = 3'd6,
        f3_bnez  = 3'd7
    } q1_funct3_e;

    typedef enum logic [2:0] {
        f3_slli = 3'd0,
        f3_lwsp = 3'd2,
        f3_cr   = 3'd4,    // jr, mv, ebreak, jalr, add
        f3_swsp = 3'd6
    } q2_funct3_e;

    typedef enum logic [3:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        sll,
        srl,
        sra,
        pass_b             // b straight through, lui
    } alu_op_e;

    // immediate layouts the decoder can assemble
    typedef enum logic [2:0] {
        ci,
        ci_lui,
        ci_sp16,
        ciw_spn,
        cj,
        cb,
        none
    } imm_fmt_e;

endpackage
